/* compile.f */
rtl/ros2_host_pkg.sv
rtl/buf_own_if.sv
rtl/app_data_arbiter.sv
rtl/buffer_owner_arbiter.sv
rtl/tx_frame_source.sv
rtl/rx_frame_monitor.sv
rtl/ros2_host_top.sv
sim/tb_ros2_host.sv

/* rtl/app_data_arbiter.sv */
`timescale 1ns/10ps

module app_data_arbiter import ros2_host_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic ether_en,
    input  logic ip_req,
    input  logic ip_rel,
    input  logic cpu_req,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    app_grant_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= GRANT_NONE;
        end else begin
            case (state)
                GRANT_NONE: begin
                    // engine wins a tie.
                    if (ip_req) begin
                        state <= GRANT_IP;
                    end else if (cpu_req) begin
                        state <= GRANT_CPU;
                    end
                end
                GRANT_IP: begin
                    if (ip_rel) begin
                        state <= GRANT_NONE;
                    end
                end
                GRANT_CPU: begin
                    if (cpu_rel) begin
                        state <= GRANT_NONE;
                    end
                end
                default: begin
                    state <= GRANT_NONE;
                end
            endcase
        end
    end

    // the whole block is invisible while ethernet is off.
    assign ip_grant  = ether_en & (state == GRANT_IP);
    assign cpu_grant = ether_en & (state == GRANT_CPU);

endmodule

/* rtl/buf_own_if.sv */
`timescale 1ns/10ps

interface buf_own_if;

    logic ip_rel;    // engine gives the buffer back.
    logic cpu_rel;   // cpu side gives the buffer back.
    logic ip_grant;
    logic cpu_grant;

    modport arbiter (
        input  ip_rel,
        input  cpu_rel,
        output ip_grant,
        output cpu_grant
    );

    modport host (
        input  cpu_grant,
        output cpu_rel
    );

    // bound to the top level ports, the testbench plays the engine.
    modport engine (
        input  ip_grant,
        output ip_rel
    );

endinterface

/* rtl/buffer_owner_arbiter.sv */
`timescale 1ns/10ps

module buffer_owner_arbiter import ros2_host_pkg::*; #(
    parameter owner_t RESET_OWNER = OWNER_IP
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ether_en,
    buf_own_if.arbiter own
);

    owner_t owner;

    // ownership only moves on the current owner's release.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= RESET_OWNER;
        end else begin
            case (owner)
                OWNER_IP: begin
                    if (own.ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (own.cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
                default: begin
                    owner <= RESET_OWNER;
                end
            endcase
        end
    end

    assign own.ip_grant  = ether_en & (owner == OWNER_IP);
    assign own.cpu_grant = ether_en & (owner == OWNER_CPU);

endmodule

/* rtl/ros2_host_pkg.sv */
package ros2_host_pkg;

    localparam int BUF_WORD_W   = 32;
    localparam int RXBUF_AWIDTH = 6;
    localparam int TXBUF_AWIDTH = 6;
    localparam int FRAME_SIZE_W = 16;

    // one word of either udp buffer.
    typedef logic [BUF_WORD_W-1:0]   buf_word_t;
    typedef logic [RXBUF_AWIDTH-1:0] rxbuf_addr_t;
    typedef logic [TXBUF_AWIDTH-1:0] txbuf_addr_t;
    typedef logic [FRAME_SIZE_W-1:0] frame_size_t; // bytes.

    // owner of a udp buffer.
    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } owner_t;

    // app data arbiter state, one hot per grant.
    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_t;

    // frame size lives in the upper half of this word.
    localparam rxbuf_addr_t RX_SIZE_WORD_ADDR = 6'd1;

    // led class bounds, inclusive.
    localparam frame_size_t RED_MAX_SIZE   = 16'd10;
    localparam frame_size_t GREEN_MAX_SIZE = 16'd20;

endpackage

/* rtl/ros2_host_top.sv */
`timescale 1ns/10ps

module ros2_host_top import ros2_host_pkg::*; #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ether_en,

    // application data block.
    input  logic        app_data_ip_req,
    input  logic        app_data_ip_rel,
    input  logic        app_data_cpu_req,
    input  logic        app_data_cpu_rel,
    output logic        app_data_ip_grant,
    output logic        app_data_cpu_grant,

    // udp receive buffer, engine side.
    input  logic        rxbuf_ip_rel,
    output logic        rxbuf_ip_grant,
    input  rxbuf_addr_t rxbuf_addr,
    input  logic        rxbuf_we,
    input  buf_word_t   rxbuf_wdata,

    // udp transmit buffer, engine side.
    input  logic        txbuf_ip_rel,
    output logic        txbuf_ip_grant,
    input  txbuf_addr_t txbuf_addr,
    output buf_word_t   txbuf_rdata,

    output logic        led_r,
    output logic        led_g,
    output logic        led_b
);

    buf_own_if rx_own ();
    buf_own_if tx_own ();

    // engine side of both buffers comes from the ports.
    assign rx_own.ip_rel  = rxbuf_ip_rel;
    assign rxbuf_ip_grant = rx_own.ip_grant;
    assign tx_own.ip_rel  = txbuf_ip_rel;
    assign txbuf_ip_grant = tx_own.ip_grant;

    app_data_arbiter i_app_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .ether_en  (ether_en),
        .ip_req    (app_data_ip_req),
        .ip_rel    (app_data_ip_rel),
        .cpu_req   (app_data_cpu_req),
        .cpu_rel   (app_data_cpu_rel),
        .ip_grant  (app_data_ip_grant),
        .cpu_grant (app_data_cpu_grant)
    );

    // engine owns the receive buffer out of reset.
    buffer_owner_arbiter #(
        .RESET_OWNER (OWNER_IP)
    ) i_rx_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .ether_en (ether_en),
        .own      (rx_own.arbiter)
    );

    // cpu owns the transmit buffer until the first frame is ready.
    buffer_owner_arbiter #(
        .RESET_OWNER (OWNER_CPU)
    ) i_tx_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .ether_en (ether_en),
        .own      (tx_own.arbiter)
    );

    tx_frame_source #(
        .TX_PERIOD_LOG2 (TX_PERIOD_LOG2)
    ) i_tx_src (
        .clk         (clk),
        .rst_n       (rst_n),
        .txbuf_addr  (txbuf_addr),
        .txbuf_rdata (txbuf_rdata),
        .own         (tx_own.host)
    );

    rx_frame_monitor i_rx_mon (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxbuf_addr  (rxbuf_addr),
        .rxbuf_we    (rxbuf_we),
        .rxbuf_wdata (rxbuf_wdata),
        .led_r       (led_r),
        .led_g       (led_g),
        .led_b       (led_b),
        .own         (rx_own.host)
    );

endmodule

/* rtl/rx_frame_monitor.sv */
`timescale 1ns/10ps

module rx_frame_monitor import ros2_host_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  rxbuf_addr_t rxbuf_addr,
    input  logic        rxbuf_we,
    input  buf_word_t   rxbuf_wdata,
    output logic        led_r,
    output logic        led_g,
    output logic        led_b,
    buf_own_if.host     own
);

    logic        rx_rel;
    frame_size_t last_rx_size;

    // give the buffer straight back once we own it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_rel <= 1'b0;
        end else begin
            rx_rel <= own.cpu_grant;
        end
    end

    assign own.cpu_rel = rx_rel;

    // snoop the size word as the engine writes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rx_size <= '0; // keeps the leds dark until a frame.
        end else if (rxbuf_we && (rxbuf_addr == RX_SIZE_WORD_ADDR)) begin
            last_rx_size <= rxbuf_wdata[BUF_WORD_W-1 -: FRAME_SIZE_W];
        end
    end

    assign led_r = (last_rx_size != '0) && (last_rx_size <= RED_MAX_SIZE);
    assign led_g = (last_rx_size > RED_MAX_SIZE) && (last_rx_size <= GREEN_MAX_SIZE);
    assign led_b = (last_rx_size > GREEN_MAX_SIZE);

endmodule

/* rtl/tx_frame_source.sv */
`timescale 1ns/10ps

module tx_frame_source import ros2_host_pkg::*; #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic        clk,
    input  logic        rst_n,
    input  txbuf_addr_t txbuf_addr,
    output buf_word_t   txbuf_rdata,
    buf_own_if.host     own
);

    logic [TX_PERIOD_LOG2:0] tx_cnt;
    logic                    tx_rel;

    // period is 2^TX_PERIOD_LOG2 + 1 cycles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt <= '0;
            tx_rel <= 1'b0;
        end else begin
            if (tx_cnt[TX_PERIOD_LOG2]) begin
                tx_rel <= 1'b1; // hand the buffer to the engine.
                tx_cnt <= '0;
            end else begin
                tx_rel <= 1'b0;
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    assign own.cpu_rel = tx_rel;

    // frame image, read one word per cycle by the engine.
    // the engine may read at any time, ownership is its own business.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txbuf_rdata <= '0;
        end else begin
            case (txbuf_addr)
                6'd0: begin
                    txbuf_rdata <= 32'h0a01a8c0; // destination ip.
                end
                6'd1: begin
                    txbuf_rdata <= 32'h045704d2; // udp ports.
                end
                6'd2: begin
                    txbuf_rdata <= 32'h00000007; // payload length.
                end
                6'd3: begin
                    txbuf_rdata <= 32'h626f6f66;
                end
                6'd4: begin
                    txbuf_rdata <= 32'h000a7261;
                end
                default: begin
                    txbuf_rdata <= '0;
                end
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_ros2_host \
    -f compile.f --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "run_sim: compile step failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "run_sim: failure reported in $LOG"
    exit 1
fi

echo "run_sim: no failure found in $LOG"
exit 0

/* sim/tb_ros2_host.sv */
`timescale 1ns/10ps

module tb_ros2_host import ros2_host_pkg::*; ();

    localparam int TX_PERIOD_LOG2 = 4;
    localparam int TX_PERIOD      = (1 << TX_PERIOD_LOG2) + 1;
    localparam int TX_WAIT_LIMIT  = TX_PERIOD + 2; // cycles.

    logic        clk;
    logic        rst_n;
    logic        ether_en;
    logic        app_data_ip_req;
    logic        app_data_ip_rel;
    logic        app_data_cpu_req;
    logic        app_data_cpu_rel;
    logic        app_data_ip_grant;
    logic        app_data_cpu_grant;
    logic        rxbuf_ip_rel;
    logic        rxbuf_ip_grant;
    rxbuf_addr_t rxbuf_addr;
    logic        rxbuf_we;
    buf_word_t   rxbuf_wdata;
    logic        txbuf_ip_rel;
    logic        txbuf_ip_grant;
    txbuf_addr_t txbuf_addr;
    buf_word_t   txbuf_rdata;
    logic        led_r;
    logic        led_g;
    logic        led_b;

    int          value_errors   = 0;
    int          timeout_errors = 0;
    logic [31:0] rand_state     = 32'h8a2b3749;
    logic        app_check_en   = 1'b0;
    logic        app_check_now;
    app_grant_t  exp_app        = GRANT_NONE; // model of the app data arbiter.

    ros2_host_top #(
        .TX_PERIOD_LOG2 (TX_PERIOD_LOG2)
    ) i_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .ether_en           (ether_en),
        .app_data_ip_req    (app_data_ip_req),
        .app_data_ip_rel    (app_data_ip_rel),
        .app_data_cpu_req   (app_data_cpu_req),
        .app_data_cpu_rel   (app_data_cpu_rel),
        .app_data_ip_grant  (app_data_ip_grant),
        .app_data_cpu_grant (app_data_cpu_grant),
        .rxbuf_ip_rel       (rxbuf_ip_rel),
        .rxbuf_ip_grant     (rxbuf_ip_grant),
        .rxbuf_addr         (rxbuf_addr),
        .rxbuf_we           (rxbuf_we),
        .rxbuf_wdata        (rxbuf_wdata),
        .txbuf_ip_rel       (txbuf_ip_rel),
        .txbuf_ip_grant     (txbuf_ip_grant),
        .txbuf_addr         (txbuf_addr),
        .txbuf_rdata        (txbuf_rdata),
        .led_r              (led_r),
        .led_g              (led_g),
        .led_b              (led_b)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic buf_word_t expected_frame_word(input txbuf_addr_t addr);
        case (addr)
            6'd0:    return 32'h0a01a8c0;
            6'd1:    return 32'h045704d2;
            6'd2:    return 32'h00000007;
            6'd3:    return 32'h626f6f66;
            6'd4:    return 32'h000a7261;
            default: return '0;
        endcase
    endfunction

    // {red, green, blue} for a frame size.
    function automatic logic [2:0] expected_leds(input frame_size_t size);
        if (size == '0) begin
            return 3'b000;
        end else if (size <= RED_MAX_SIZE) begin
            return 3'b100;
        end else if (size <= GREEN_MAX_SIZE) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    function automatic app_grant_t next_app_state(
        input app_grant_t s,
        input logic       ip_req,
        input logic       ip_rel,
        input logic       cpu_req,
        input logic       cpu_rel
    );
        app_grant_t n;
        n = s;
        case (s)
            GRANT_NONE: begin
                if (ip_req) begin
                    n = GRANT_IP;
                end else if (cpu_req) begin
                    n = GRANT_CPU;
                end
            end
            GRANT_IP: begin
                if (ip_rel) begin
                    n = GRANT_NONE;
                end
            end
            GRANT_CPU: begin
                if (cpu_rel) begin
                    n = GRANT_NONE;
                end
            end
            default: begin
                n = GRANT_NONE;
            end
        endcase
        return n;
    endfunction

    task automatic check_word(input string name, input buf_word_t got, input buf_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_leds(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic wait_tx_grant(input int limit);
        int n;
        n = 0;
        while (!txbuf_ip_grant && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!txbuf_ip_grant) begin
            timeout_errors++;
            $display("ERROR: txbuf_ip_grant did not rise within %0d cycles", limit);
        end
    endtask

    // model steps on the rising edge and is compared on the falling one.
    always begin
        @(posedge clk);
        if (!rst_n) begin
            exp_app = GRANT_NONE;
        end else begin
            exp_app = next_app_state(exp_app, app_data_ip_req, app_data_ip_rel,
                                     app_data_cpu_req, app_data_cpu_rel);
        end
        app_check_now = app_check_en;
        @(negedge clk);
        if (app_check_now) begin
            check_bit("app_data_ip_grant", app_data_ip_grant, exp_app == GRANT_IP);
            check_bit("app_data_cpu_grant", app_data_cpu_grant, exp_app == GRANT_CPU);
        end
    end

    initial begin
        int          i;
        logic [31:0] r;
        frame_size_t size;
        frame_size_t exp_size;
        txbuf_addr_t addr_q;

        rst_n            = 1'b0;
        ether_en         = 1'b1;
        app_data_ip_req  = 1'b0;
        app_data_ip_rel  = 1'b0;
        app_data_cpu_req = 1'b0;
        app_data_cpu_rel = 1'b0;
        rxbuf_ip_rel     = 1'b0;
        rxbuf_addr       = '0;
        rxbuf_we         = 1'b0;
        rxbuf_wdata      = '0;
        txbuf_ip_rel     = 1'b0;
        txbuf_addr       = '0; // nonzero frame word, masked by reset.
        repeat (5) @(negedge clk);
        check_word("txbuf_rdata", txbuf_rdata, '0);
        rst_n      = 1'b1;
        txbuf_addr = 6'd63; // outside the frame image.
        @(negedge clk);

        check_bit("app_data_ip_grant", app_data_ip_grant, 1'b0);
        check_bit("app_data_cpu_grant", app_data_cpu_grant, 1'b0);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b1);
        check_bit("txbuf_ip_grant", txbuf_ip_grant, 1'b0);
        check_leds("led_rgb", {led_r, led_g, led_b}, 3'b000);
        check_word("txbuf_rdata", txbuf_rdata, '0);

        // first transmit handover, one period after reset.
        wait_tx_grant(TX_WAIT_LIMIT);

        // random app data traffic.
        app_check_en = 1'b1;
        for (i = 0; i < 300; i++) begin
            rand_state       = lcg_next(rand_state);
            r                = rand_state;
            app_data_ip_req  = r[31];
            app_data_cpu_req = r[30];
            app_data_ip_rel  = (r[29:28] == 2'b00);
            app_data_cpu_rel = (r[27:26] == 2'b00);
            @(negedge clk);
        end
        app_check_en     = 1'b0;
        app_data_ip_req  = 1'b0;
        app_data_ip_rel  = 1'b0;
        app_data_cpu_req = 1'b0;
        app_data_cpu_rel = 1'b0;

        // receive handover through the cpu's registered release.
        rxbuf_ip_rel = 1'b1;
        @(negedge clk);
        rxbuf_ip_rel = 1'b0;
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b0);
        @(negedge clk);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b0);
        @(negedge clk);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b1);

        // with ethernet off the cpu never releases.
        ether_en     = 1'b0;
        rxbuf_ip_rel = 1'b1;
        @(negedge clk);
        rxbuf_ip_rel = 1'b0;
        for (i = 0; i < 8; i++) begin
            check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b0);
            check_bit("txbuf_ip_grant", txbuf_ip_grant, 1'b0);
            @(negedge clk);
        end
        ether_en = 1'b1;
        @(negedge clk);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b0);
        @(negedge clk);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, 1'b1);

        // engine still holds the transmit buffer.
        check_bit("txbuf_ip_grant", txbuf_ip_grant, 1'b1);
        txbuf_ip_rel = 1'b1;
        @(negedge clk);
        txbuf_ip_rel = 1'b0;
        check_bit("txbuf_ip_grant", txbuf_ip_grant, 1'b0);
        wait_tx_grant(TX_WAIT_LIMIT);

        // frame image reads.
        for (i = 0; i < 48; i++) begin
            rand_state = lcg_next(rand_state);
            r          = rand_state;
            if (r[31]) begin
                txbuf_addr = {3'b000, r[26:24]}; // mostly inside the image.
            end else begin
                txbuf_addr = r[29:24];
            end
            addr_q = txbuf_addr;
            @(negedge clk);
            check_word("txbuf_rdata", txbuf_rdata, expected_frame_word(addr_q));
        end

        // size word writes and the led class.
        exp_size = '0;
        for (i = 0; i < 64; i++) begin
            rand_state = lcg_next(rand_state);
            r          = rand_state;
            size       = {11'd0, r[31:27]};
            if (r[26]) begin
                size = r[25:10];
            end
            rxbuf_we    = (r[9:8] != 2'b00);
            rxbuf_addr  = (r[7:6] != 2'b00) ? RX_SIZE_WORD_ADDR : r[21:16];
            rxbuf_wdata = {size, r[15:0]};
            if (rxbuf_we && (rxbuf_addr == RX_SIZE_WORD_ADDR)) begin
                exp_size = size;
            end
            @(negedge clk);
            check_leds("led_rgb", {led_r, led_g, led_b}, expected_leds(exp_size));
        end
        rxbuf_we = 1'b0;
        @(negedge clk);

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
